// File: src/vlb_pkg.sv
package vlb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and frame constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int BYTE_W      = 32;
    localparam int TOR_ID_W    = 3;
    localparam int SLOT_ID_W   = 1;
    localparam int BEAT_W      = 64;
    localparam int KEEP_W      = 8;
    localparam int FRAME_BEATS = 9;

    localparam logic [15:0] CAPACITY_TYPE = 16'hff00;
    // upper part of every tor address
    localparam logic [31:0] MAC_HEAD      = 32'h8dbc_5c4a;

    ////////////////////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////////////////////

    // one byte count per destination tor
    typedef logic [7:0][BYTE_W-1:0] queue_sizes_t;

    typedef struct packed {
        logic [TOR_ID_W-1:0] direct_tor;
        logic [BYTE_W-1:0]   relay_bytes;
        logic [BYTE_W-1:0]   direct_bytes;
        logic [BYTE_W-1:0]   two_hop_bytes;
        logic [BYTE_W-1:0]   capacity_bytes;
    } slot_budget_t;

    typedef struct packed {
        logic [TOR_ID_W-1:0] dest_tor;
        logic [BYTE_W-1:0]   capacity_bytes;
        logic [BYTE_W-1:0]   two_hop_bytes;
    } frame_desc_t;

    typedef struct packed {
        logic [BYTE_W-1:0] peer_capacity;
        logic [BYTE_W-1:0] peer_two_hop;
    } peer_report_t;

    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } axis_beat_t;

endpackage

// File: src/slot_budget_planner.sv
`timescale 1ns/1ps

module slot_budget_planner
    import vlb_pkg::*;
#(
    parameter int TOR_NUM        = 8,
    parameter int OCS_ID         = 0,
    parameter int MY_TOR_ID      = 0,
    parameter int SLOT_MAX_BYTES = 262144
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_slot_start,
    input  logic [SLOT_ID_W-1:0] i_slot_id,
    input  queue_sizes_t         i_local_queue,
    input  queue_sizes_t         i_unlocal_queue,
    output slot_budget_t         o_budget,
    output logic                 o_budget_valid,
    output frame_desc_t          o_desc,
    output logic                 o_desc_push
);

    localparam logic [BYTE_W-1:0] MAX_BYTES = BYTE_W'(SLOT_MAX_BYTES);
    localparam int SLOTS = 2 ** SLOT_ID_W;

    logic [2:0]           r_step;
    logic [SLOT_ID_W-1:0] r_slot;
    logic [TOR_ID_W-1:0]  r_direct_tor;
    logic [TOR_ID_W-1:0]  r_two_hop_tor;
    logic [BYTE_W-1:0]    r_relay;
    logic [BYTE_W-1:0]    r_direct;
    logic [BYTE_W-1:0]    r_two_hop;
    logic [BYTE_W-1:0]    w_left_relay;
    logic [BYTE_W-1:0]    w_left_direct;
    logic [BYTE_W-1:0]    w_capacity;
    logic [BYTE_W-1:0]    w_relay_raw;
    logic [BYTE_W-1:0]    w_direct_want;
    logic [BYTE_W-1:0]    w_two_hop_want;
    logic [BYTE_W+1:0]    w_budget_sum;
    logic [TOR_ID_W-1:0]  route_table [TOR_NUM][SLOTS];

    // rotor pattern of this port's ocs
    function automatic logic [TOR_ID_W-1:0] route(input int tor, input int slot);
        int hop;
        int dst;
        hop = (2 * slot + 1) % TOR_NUM;
        if (OCS_ID == 0) begin
            dst = (tor + hop) % TOR_NUM;
        end else begin
            dst = (tor + TOR_NUM - hop) % TOR_NUM;
        end
        return TOR_ID_W'(dst);
    endfunction

    always_comb begin
        for (int t = 0; t < TOR_NUM; t++) begin
            for (int s = 0; s < SLOTS; s++) begin
                route_table[t][s] = route(t, s);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // budget arithmetic
    ////////////////////////////////////////////////////////////////////////////

    assign w_relay_raw    = i_unlocal_queue[r_direct_tor];
    assign w_direct_want  = i_local_queue[r_direct_tor];
    assign w_two_hop_want = i_local_queue[r_two_hop_tor];

    // remainders cannot wrap, relay is clipped to one slot
    assign w_left_relay  = MAX_BYTES - r_relay;
    assign w_left_direct = w_left_relay - r_direct;
    assign w_capacity    = w_left_direct - r_two_hop;

    // step 0 idle, steps 1 to 5 walk the computation
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_step         <= 3'd0;
            o_budget_valid <= 1'b0;
        end else begin
            o_budget_valid <= (r_step == 3'd5);
            if (r_step == 3'd0) begin
                if (i_slot_start) begin
                    r_step <= 3'd1;
                end
            end else if (r_step == 3'd5) begin
                r_step <= 3'd0;
            end else begin
                r_step <= r_step + 3'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_step == 3'd0 && i_slot_start) begin
            r_slot <= i_slot_id;
        end
        case (r_step)
            3'd1: r_direct_tor <= route_table[MY_TOR_ID][r_slot];
            3'd2: begin
                r_relay       <= (w_relay_raw > MAX_BYTES) ? MAX_BYTES : w_relay_raw;
                r_two_hop_tor <= route_table[r_direct_tor][r_slot];
            end
            3'd3: r_direct <= (w_direct_want < w_left_relay) ? w_direct_want : w_left_relay;
            3'd4: r_two_hop <= (w_two_hop_want < w_left_direct) ? w_two_hop_want
                                                                  : w_left_direct;
            3'd5: begin
                o_budget.direct_tor     <= r_direct_tor;
                o_budget.relay_bytes    <= r_relay;
                o_budget.direct_bytes   <= r_direct;
                o_budget.two_hop_bytes  <= r_two_hop;
                o_budget.capacity_bytes <= w_capacity;
            end
            default: ;
        endcase
    end

    // descriptor goes to the fifo with the budget pulse
    assign o_desc.dest_tor       = o_budget.direct_tor;
    assign o_desc.capacity_bytes = o_budget.capacity_bytes;
    assign o_desc.two_hop_bytes  = o_budget.two_hop_bytes;
    assign o_desc_push           = o_budget_valid;

    assign w_budget_sum = {2'b00, o_budget.relay_bytes} + {2'b00, o_budget.direct_bytes}
                        + {2'b00, o_budget.two_hop_bytes} + {2'b00, o_budget.capacity_bytes};

    a_budget_fits: assert property (@(posedge i_clk) disable iff (i_rst)
        o_budget_valid |-> (w_budget_sum <= {2'b00, MAX_BYTES}));

endmodule

// File: src/frame_desc_fifo.sv
`timescale 1ns/1ps

module frame_desc_fifo
    import vlb_pkg::*;
#(
    parameter int FIFO_DEPTH = 2
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_push,
    input  frame_desc_t i_desc,
    input  logic        i_pop,
    output frame_desc_t o_head,
    output logic        o_not_empty,
    output logic        o_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    frame_desc_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (i_push) begin
                r_wr_ptr <= next_ptr(r_wr_ptr);
            end
            if (i_pop) begin
                r_rd_ptr <= next_ptr(r_rd_ptr);
            end
            if (i_push && !i_pop) begin
                r_count <= r_count + 1'b1;
            end else if (i_pop && !i_push) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[r_wr_ptr] <= i_desc;
        end
    end

    assign o_head      = mem[r_rd_ptr];
    assign o_not_empty = (r_count != '0);
    assign o_full      = (r_count == CNT_W'(FIFO_DEPTH));

    // planner and sender must respect the fill level
    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_push && o_full));

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_pop && !o_not_empty));

endmodule

// File: src/capacity_frame_sender.sv
`timescale 1ns/1ps

module capacity_frame_sender
    import vlb_pkg::*;
#(
    parameter int MY_TOR_ID = 0
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  frame_desc_t       i_desc,
    input  logic              i_desc_ready,
    input  logic [BEAT_W-1:0] i_time_stamp,
    input  logic              i_tx_ready,
    output logic              o_pop,
    output axis_beat_t        o_tx_beat,
    output logic              o_tx_valid
);

    localparam int IDX_W = $clog2(FRAME_BEATS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_BEATS - 1);
    localparam logic [TOR_ID_W-1:0] MY_TOR = TOR_ID_W'(MY_TOR_ID);

    logic [IDX_W-1:0] r_idx;
    frame_desc_t      r_desc;
    logic             w_accept;
    logic             w_last_accept;

    // tor id sits in bits 10:8 of the address
    function automatic logic [47:0] tor_addr(input logic [TOR_ID_W-1:0] tor);
        return {MAC_HEAD, 5'd0, tor, 8'd0};
    endfunction

    function automatic axis_beat_t build_beat(input logic [IDX_W-1:0] idx,
                                              input frame_desc_t desc,
                                              input logic [BEAT_W-1:0] ts);
        axis_beat_t  beat;
        logic [47:0] my_addr;
        my_addr   = tor_addr(MY_TOR);
        beat.keep = '1;
        beat.last = (idx == LAST_IDX);
        case (idx)
            0:         beat.data = {tor_addr(desc.dest_tor), my_addr[47:32]};
            1:         beat.data = {my_addr[31:0], CAPACITY_TYPE, 16'd0};
            2:         beat.data = {desc.capacity_bytes, desc.two_hop_bytes};
            3, 4, 5, 6, 7: beat.data = ts;
            default:   beat.data = '0;
        endcase
        return beat;
    endfunction

    assign w_accept      = o_tx_valid && i_tx_ready;
    assign w_last_accept = w_accept && (r_idx == LAST_IDX);

    // a new descriptor is taken only between frames
    assign o_pop = !o_tx_valid && i_desc_ready;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_tx_valid <= 1'b0;
            r_idx      <= '0;
        end else if (o_pop) begin
            o_tx_valid <= 1'b1;
            r_idx      <= '0;
        end else if (w_last_accept) begin
            o_tx_valid <= 1'b0;
            r_idx      <= '0;
        end else if (w_accept) begin
            r_idx <= r_idx + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            r_desc    <= i_desc;
            o_tx_beat <= build_beat('0, i_desc, i_time_stamp);
        end else if (w_accept && !w_last_accept) begin
            o_tx_beat <= build_beat(r_idx + 1'b1, r_desc, i_time_stamp);
        end
    end

    a_hold_beat: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_beat)));

endmodule

// File: src/capacity_frame_parser.sv
`timescale 1ns/1ps

module capacity_frame_parser
    import vlb_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  axis_beat_t   i_rx_beat,
    input  logic         i_rx_valid,
    output peer_report_t o_peer,
    output logic         o_peer_valid
);

    localparam logic [3:0] TYPE_BEAT  = 4'd1;
    localparam logic [3:0] FIELD_BEAT = 4'd2;

    logic [3:0]   r_cnt;
    logic         r_is_cap;
    peer_report_t r_fields;
    logic         w_frame_end;

    assign w_frame_end = i_rx_valid && i_rx_beat.last;

    ////////////////////////////////////////////////////////////////////////////
    // beat counter and type match
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_cnt        <= '0;
            r_is_cap     <= 1'b0;
            o_peer_valid <= 1'b0;
        end else begin
            o_peer_valid <= w_frame_end && r_is_cap;
            if (w_frame_end) begin
                r_cnt    <= '0;
                r_is_cap <= 1'b0;
            end else if (i_rx_valid) begin
                // saturate on overlong frames
                if (r_cnt != '1) begin
                    r_cnt <= r_cnt + 4'd1;
                end
                if (r_cnt == TYPE_BEAT) begin
                    r_is_cap <= (i_rx_beat.data[31:16] == CAPACITY_TYPE);
                end
            end
        end
    end

    // fields staged so a later frame cannot disturb the report
    always_ff @(posedge i_clk) begin
        if (i_rx_valid && r_cnt == FIELD_BEAT) begin
            r_fields.peer_capacity <= i_rx_beat.data[63:32];
            r_fields.peer_two_hop  <= i_rx_beat.data[31:0];
        end
        if (w_frame_end && r_is_cap) begin
            o_peer <= r_fields;
        end
    end

endmodule

// File: src/vlb_port_top.sv
`timescale 1ns/1ps

module vlb_port_top
    import vlb_pkg::*;
#(
    parameter int TOR_NUM        = 8,
    parameter int OCS_ID         = 0,
    parameter int MY_TOR_ID      = 0,
    parameter int SLOT_MAX_BYTES = 262144,
    parameter int FIFO_DEPTH     = 2
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_slot_start,
    input  logic [SLOT_ID_W-1:0] i_slot_id,
    input  queue_sizes_t         i_local_queue,
    input  queue_sizes_t         i_unlocal_queue,
    input  logic [BEAT_W-1:0]    i_time_stamp,
    input  logic                 i_tx_ready,
    input  axis_beat_t           i_rx_beat,
    input  logic                 i_rx_valid,
    output slot_budget_t         o_budget,
    output logic                 o_budget_valid,
    output axis_beat_t           o_tx_beat,
    output logic                 o_tx_valid,
    output peer_report_t         o_peer,
    output logic                 o_peer_valid
);

    frame_desc_t w_push_desc;
    logic        w_push;
    frame_desc_t w_head_desc;
    logic        w_not_empty;
    logic        w_pop;

    ////////////////////////////////////////////////////////////////////////////
    // transmit path: planner, descriptor fifo, sender
    ////////////////////////////////////////////////////////////////////////////

    slot_budget_planner #(
        .TOR_NUM        (TOR_NUM),
        .OCS_ID         (OCS_ID),
        .MY_TOR_ID      (MY_TOR_ID),
        .SLOT_MAX_BYTES (SLOT_MAX_BYTES)
    ) u_planner (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_slot_start    (i_slot_start),
        .i_slot_id       (i_slot_id),
        .i_local_queue   (i_local_queue),
        .i_unlocal_queue (i_unlocal_queue),
        .o_budget        (o_budget),
        .o_budget_valid  (o_budget_valid),
        .o_desc          (w_push_desc),
        .o_desc_push     (w_push)
    );

    frame_desc_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_desc_fifo (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_push      (w_push),
        .i_desc      (w_push_desc),
        .i_pop       (w_pop),
        .o_head      (w_head_desc),
        .o_not_empty (w_not_empty),
        .o_full      ()
    );

    capacity_frame_sender #(
        .MY_TOR_ID (MY_TOR_ID)
    ) u_sender (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_desc       (w_head_desc),
        .i_desc_ready (w_not_empty),
        .i_time_stamp (i_time_stamp),
        .i_tx_ready   (i_tx_ready),
        .o_pop        (w_pop),
        .o_tx_beat    (o_tx_beat),
        .o_tx_valid   (o_tx_valid)
    );

    // receive path
    capacity_frame_parser u_parser (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_rx_beat    (i_rx_beat),
        .i_rx_valid   (i_rx_valid),
        .o_peer       (o_peer),
        .o_peer_valid (o_peer_valid)
    );

endmodule

// File: verif/tb_vlb_port.sv
`timescale 1ns/1ps

module tb_vlb_port
    import vlb_pkg::*;
();

    localparam int TOR_NUM    = 8;
    localparam int OCS_ID     = 1;
    localparam int MY_TOR_ID  = 2;
    localparam int SLOT_MAX   = 262144;
    localparam int FIFO_DEPTH = 2;
    // twelve slots with frames of at most ~60 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [63:0] TIME_STAMP = 64'h0123_4567_89ab_cdef;

    logic                 i_clk = 1'b0;
    logic                 i_rst;
    logic                 i_slot_start;
    logic [SLOT_ID_W-1:0] i_slot_id;
    queue_sizes_t         i_local_queue;
    queue_sizes_t         i_unlocal_queue;
    logic [BEAT_W-1:0]    i_time_stamp;
    logic                 i_tx_ready;
    axis_beat_t           i_rx_beat;
    logic                 i_rx_valid;
    slot_budget_t         o_budget;
    logic                 o_budget_valid;
    axis_beat_t           o_tx_beat;
    logic                 o_tx_valid;
    peer_report_t         o_peer;
    logic                 o_peer_valid;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          peer_pulses = 0;

    vlb_port_top #(
        .TOR_NUM        (TOR_NUM),
        .OCS_ID         (OCS_ID),
        .MY_TOR_ID      (MY_TOR_ID),
        .SLOT_MAX_BYTES (SLOT_MAX),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) dut (.*);

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(negedge i_clk) begin
        if (o_peer_valid) begin
            peer_pulses++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] random_in(input int base, input int span);
        if (span == 0) begin
            return 32'(base);
        end
        return 32'(base) + (next_random() % 32'(span));
    endfunction

    // rotor step of 2s+1, forward on ocs 0, backward on ocs 1
    function automatic int route_of(input int tor, input int slot);
        int step;
        step = 2 * slot + 1;
        if (OCS_ID == 0) begin
            return (tor + step) % TOR_NUM;
        end
        return ((tor - step) % TOR_NUM + TOR_NUM) % TOR_NUM;
    endfunction

    function automatic logic [31:0] smaller(input logic [31:0] a, input logic [31:0] b);
        return (a < b) ? a : b;
    endfunction

    function automatic slot_budget_t expected_budget(input int slot, input queue_sizes_t lq,
                                                     input queue_sizes_t uq);
        slot_budget_t b;
        int           direct;
        int           two_hop;
        logic [31:0]  room;
        direct           = route_of(MY_TOR_ID, slot);
        two_hop          = route_of(direct, slot);
        b.direct_tor     = 3'(direct);
        b.relay_bytes    = uq[direct];
        room             = 32'(SLOT_MAX) - b.relay_bytes;
        b.direct_bytes   = smaller(lq[direct], room);
        room             = room - b.direct_bytes;
        b.two_hop_bytes  = smaller(lq[two_hop], room);
        b.capacity_bytes = room - b.two_hop_bytes;
        return b;
    endfunction

    function automatic logic [47:0] mac_of(input logic [2:0] tor);
        return {MAC_HEAD, 5'd0, tor, 8'd0};
    endfunction

    function automatic axis_beat_t expected_beat(input int idx, input slot_budget_t b);
        axis_beat_t  beat;
        logic [47:0] src;
        src       = mac_of(3'(MY_TOR_ID));
        beat.keep = 8'hff;
        beat.last = (idx == FRAME_BEATS - 1);
        if (idx == 0) begin
            beat.data = {mac_of(b.direct_tor), src[47:32]};
        end else if (idx == 1) begin
            beat.data = {src[31:0], 16'hff00, 16'h0000};
        end else if (idx == 2) begin
            beat.data = {b.capacity_bytes, b.two_hop_bytes};
        end else if (idx <= 7) begin
            beat.data = TIME_STAMP;
        end else begin
            beat.data = 64'd0;
        end
        return beat;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // driver and check tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_equal(input logic [255:0] got, input logic [255:0] want,
                               input string what);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
            $display("Test failures found");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic fill_queues(input int l_base, input int l_span, input int u_base,
                               input int u_span);
        for (int t = 0; t < TOR_NUM; t++) begin
            i_local_queue[t]   = random_in(l_base, l_span);
            i_unlocal_queue[t] = random_in(u_base, u_span);
        end
    endtask

    // called and returns on a falling edge
    task automatic run_slot(input int slot, output slot_budget_t exp);
        int waited;
        exp          = expected_budget(slot, i_local_queue, i_unlocal_queue);
        i_slot_id    = SLOT_ID_W'(slot);
        i_slot_start = 1'b1;
        @(negedge i_clk);
        i_slot_start = 1'b0;
        waited       = 0;
        while (!o_budget_valid) begin
            @(negedge i_clk);
            waited++;
        end
        check_equal(waited, 5, "budget latency");
        check_equal(o_budget, exp, "budget");
    endtask

    // the beat present at the calling edge is checked too
    task automatic receive_frame(input slot_budget_t exp, input bit random_ready);
        int          idx;
        logic [31:0] r;
        idx = 0;
        while (idx < FRAME_BEATS) begin
            r          = next_random();
            i_tx_ready = random_ready ? r[3] : 1'b1;
            if (o_tx_valid && i_tx_ready) begin
                check_equal(o_tx_beat, expected_beat(idx, exp),
                            $sformatf("frame beat %0d", idx));
                idx++;
            end
            @(negedge i_clk);
        end
    endtask

    task automatic send_rx_frame(input logic [15:0] type_code, input logic [31:0] cap,
                                 input logic [31:0] two_hop);
        axis_beat_t beat;
        for (int idx = 0; idx < FRAME_BEATS; idx++) begin
            @(negedge i_clk);
            if (idx == 5) begin
                // idle gap inside the frame
                i_rx_valid = 1'b0;
                @(negedge i_clk);
            end
            beat.keep = 8'hff;
            beat.last = (idx == FRAME_BEATS - 1);
            beat.data = 64'(idx) * 64'h0101_0101_0101_0101;
            if (idx == 1) begin
                beat.data = {32'd0, type_code, 16'd0};
            end else if (idx == 2) begin
                beat.data = {cap, two_hop};
            end
            i_rx_beat  = beat;
            i_rx_valid = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_budget_small();
        slot_budget_t exp;
        for (int s = 0; s < 2; s++) begin
            fill_queues(0, 4096, 0, 4096);
            run_slot(s, exp);
            receive_frame(exp, 1'b0);
        end
    endtask

    task automatic test_budget_saturation();
        slot_budget_t exp;
        fill_queues(SLOT_MAX / 4, 0, SLOT_MAX / 4, 0);
        run_slot(0, exp);
        check_equal(o_budget.capacity_bytes, SLOT_MAX / 4, "capacity with room left");
        receive_frame(exp, 1'b0);
        // local queues fill the whole slot
        fill_queues(SLOT_MAX, 0, SLOT_MAX / 4, 0);
        run_slot(1, exp);
        check_equal(o_budget.direct_bytes, SLOT_MAX * 3 / 4, "clipped direct");
        check_equal(o_budget.capacity_bytes, 0, "capacity when full");
        receive_frame(exp, 1'b0);
        fill_queues(SLOT_MAX / 2, 0, SLOT_MAX, 0);
        run_slot(0, exp);
        check_equal(o_budget.direct_bytes, 0, "direct behind full relay");
        receive_frame(exp, 1'b0);
        for (int n = 0; n < 4; n++) begin
            fill_queues(SLOT_MAX / 4, SLOT_MAX / 2, 0, SLOT_MAX / 2);
            run_slot(n % 2, exp);
            receive_frame(exp, 1'b0);
        end
    endtask

    task automatic test_frame_ready_high();
        slot_budget_t exp;
        int           waited;
        fill_queues(1000, 50000, 1000, 50000);
        i_tx_ready = 1'b1;
        run_slot(1, exp);
        waited = 0;
        while (!o_tx_valid) begin
            @(negedge i_clk);
            waited++;
        end
        check_equal(waited >= 2, 1'b1, "frame start after budget");
        receive_frame(exp, 1'b0);
    endtask

    task automatic test_back_pressure();
        slot_budget_t first;
        slot_budget_t second;
        i_tx_ready = 1'b0;
        fill_queues(0, 100000, 0, 100000);
        run_slot(0, first);
        fill_queues(0, 100000, 0, 100000);
        run_slot(1, second);
        receive_frame(first, 1'b1);
        receive_frame(second, 1'b1);
    endtask

    task automatic test_parser();
        logic [31:0] cap;
        logic [31:0] two_hop;
        cap         = next_random();
        two_hop     = next_random();
        peer_pulses = 0;
        send_rx_frame(CAPACITY_TYPE, cap, two_hop);
        @(negedge i_clk);
        i_rx_valid = 1'b0;
        check_equal(o_peer_valid, 1'b1, "peer valid after last beat");
        check_equal(o_peer, {cap, two_hop}, "peer report");
        // another frame type must pass unreported
        send_rx_frame(16'h0800, ~cap, ~two_hop);
        @(negedge i_clk);
        i_rx_valid = 1'b0;
        repeat (3) @(negedge i_clk);
        check_equal(peer_pulses, 1, "peer report count");
        check_equal(o_peer, {cap, two_hop}, "peer report after other frame");
    endtask

    initial begin
        i_rst           = 1'b1;
        i_slot_start    = 1'b0;
        i_slot_id       = '0;
        i_local_queue   = '0;
        i_unlocal_queue = '0;
        i_time_stamp    = TIME_STAMP;
        i_tx_ready      = 1'b1;
        i_rx_beat       = '0;
        i_rx_valid      = 1'b0;
        rng_state       = 32'd10178;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        check_equal(o_budget_valid, 1'b0, "budget valid after reset");
        check_equal(o_tx_valid, 1'b0, "tx valid after reset");
        check_equal(o_peer_valid, 1'b0, "peer valid after reset");
        test_budget_small();
        test_budget_saturation();
        test_frame_ready_high();
        test_back_pressure();
        test_parser();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: all.f
src/vlb_pkg.sv
src/slot_budget_planner.sv
src/frame_desc_fifo.sv
src/capacity_frame_sender.sv
src/capacity_frame_parser.sv
src/vlb_port_top.sv
verif/tb_vlb_port.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_vlb_port -o sim_vlb_port
./obj_dir/sim_vlb_port 2>&1 | tee sim.log
if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
